/* all.f */
+incdir+include
hw/node_flit_pkg.sv
hw/node_route_pkg.sv
hw/node_in_buffer.sv
hw/node_out_port.sv
hw/node_row_router.sv
verif/node_asserts.sv
verif/node_checker.sv
verif/node_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the row router testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module node_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vnode_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
    echo "no result line in sim.log"
    exit 1
fi
exit 0

/* verif/node_tb.sv */
/*
 * testbench of the row router at X = 3
 * clock, reset, stimulus table, credit models, random traffic
 */

`timescale 1ns/1ps
`include "node_macros.svh"

module node_tb;

    localparam int W = `NODE_FLIT_W;
    localparam int P_W = 1, P_E = 2;
    localparam int M_ROUTE = 0, M_BP = 4;

    typedef struct packed {
        logic [3:0] test;
        logic [1:0] port;
        logic [2:0] tgt;
        logic       qos;
        logic [7:0] data;
        logic [5:0] off;    // cycle offset within the test
    } stim_t;

    localparam int N_STIM = 25;
    stim_t stim [N_STIM] = '{
        '{4'd0, 2'd0, 3'd5, 1'b0, 8'h11, 6'd0}, '{4'd0, 2'd0, 3'd1, 1'b0, 8'h12, 6'd1},
        '{4'd0, 2'd0, 3'd3, 1'b0, 8'h13, 6'd2}, '{4'd0, 2'd1, 3'd6, 1'b0, 8'h21, 6'd0},
        '{4'd0, 2'd1, 3'd3, 1'b1, 8'h22, 6'd1}, '{4'd0, 2'd2, 3'd0, 1'b0, 8'h31, 6'd0},
        '{4'd0, 2'd2, 3'd3, 1'b0, 8'h32, 6'd1}, '{4'd0, 2'd2, 3'd2, 1'b1, 8'h33, 6'd2},
        '{4'd1, 2'd0, 3'd3, 1'b0, 8'h41, 6'd0}, '{4'd1, 2'd1, 3'd7, 1'b0, 8'h42, 6'd4},
        '{4'd1, 2'd2, 3'd1, 1'b0, 8'h43, 6'd8},
        '{4'd2, 2'd0, 3'd6, 1'b0, 8'h51, 6'd0}, '{4'd2, 2'd1, 3'd7, 1'b1, 8'h52, 6'd0},
        '{4'd3, 2'd0, 3'd5, 1'b0, 8'h61, 6'd0}, '{4'd3, 2'd1, 3'd5, 1'b0, 8'h62, 6'd0},
        '{4'd3, 2'd0, 3'd5, 1'b0, 8'h63, 6'd1}, '{4'd3, 2'd1, 3'd5, 1'b0, 8'h64, 6'd1},
        '{4'd3, 2'd0, 3'd5, 1'b0, 8'h65, 6'd2}, '{4'd3, 2'd1, 3'd5, 1'b0, 8'h66, 6'd2},
        '{4'd4, 2'd0, 3'd5, 1'b0, 8'h71, 6'd0}, '{4'd4, 2'd1, 3'd4, 1'b0, 8'h72, 6'd0},
        '{4'd4, 2'd0, 3'd5, 1'b0, 8'h73, 6'd1}, '{4'd4, 2'd1, 3'd4, 1'b0, 8'h74, 6'd1},
        '{4'd4, 2'd0, 3'd5, 1'b0, 8'h75, 6'd2}, '{4'd4, 2'd1, 3'd4, 1'b0, 8'h76, 6'd2}
    };

    logic           clk;
    logic           rst_n_i;
    logic [2:0]     in_valid;    // a, w, e
    logic [2:0][W-1:0] in_flit;
    logic [2:0]     in_credit;
    logic [2:0]     out_valid;   // b, e, w
    logic [2:0][W-1:0] out_flit;
    logic [2:0]     out_credit;
    logic [2:0]     mode_r;
    logic           hold, start_s, end_s, done_s, timed_out;
    int             test_id, err_cnt, pending, seq;
    int             up_cred [3];
    int             ret_pend [3];
    logic [31:0]    rng;

    node_row_router #(.LOCAL_X(3)) node_row_router_inst (
        .clk (clk), .rst_n_i (rst_n_i),
        .a_valid_i (in_valid[0]), .a_flit_i (in_flit[0]), .a_credit_o (in_credit[0]),
        .w_valid_i (in_valid[1]), .w_flit_i (in_flit[1]), .w_credit_o (in_credit[1]),
        .e_valid_i (in_valid[2]), .e_flit_i (in_flit[2]), .e_credit_o (in_credit[2]),
        .b_valid_o (out_valid[0]), .b_flit_o (out_flit[0]), .b_credit_i (out_credit[0]),
        .e_valid_o (out_valid[1]), .e_flit_o (out_flit[1]), .e_credit_i (out_credit[1]),
        .w_valid_o (out_valid[2]), .w_flit_o (out_flit[2]), .w_credit_i (out_credit[2])
    );

    node_checker #(.LOCAL_X(3)) u_checker (
        .clk (clk), .rst_n_i (rst_n_i),
        .in_valid_i (in_valid), .in_flit_i (in_flit), .in_credit_i (in_credit),
        .out_valid_i (out_valid), .out_flit_i (out_flit),
        .mode_i (mode_r), .hold_i (hold), .start_i (start_s), .end_i (end_s),
        .done_i (done_s), .test_id_i (test_id), .err_o (err_cnt), .pending_o (pending)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ==================================================
    // credit models
    // ==================================================
    always @(posedge clk) begin : upstream_credits
        for (int i = 0; i < 3; i++) begin
            if (!rst_n_i) up_cred[i] = `NODE_CREDITS;
            else up_cred[i] = up_cred[i] - int'(in_valid[i]) + int'(in_credit[i]);
        end
    end

    always @(posedge clk) begin : downstream_credits
        logic [2:0] v;
        logic       h;
        logic       r;
        v = out_valid;    // value of the cycle just ended
        h = hold;
        r = rst_n_i;
        #1;
        for (int o = 0; o < 3; o++) begin
            if (!r) ret_pend[o] = 0;
            else ret_pend[o] += int'(v[o]);
            out_credit[o] = 1'b0;
            if (r && ret_pend[o] > 0 && !(h && o == 1)) begin
                out_credit[o] = 1'b1;    // one credit back per cycle
                ret_pend[o]--;
            end
        end
    end

    // ==================================================
    // stimulus helpers
    // ==================================================
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
        in_valid = '0;
        start_s  = 1'b0;
        end_s    = 1'b0;
        done_s   = 1'b0;
    endtask

    task automatic wait_credit(input logic [2:0] mask);
        int n;
        n = 0;
        while (((mask[0] && up_cred[0] == 0) || (mask[1] && up_cred[1] == 0) ||
                (mask[2] && up_cred[2] == 0)) && n < 100) begin
            next_cycle();
            n++;
        end
        if (n >= 100) begin
            timed_out = 1'b1;
            $display("timeout: no upstream credit came back in test %0d", test_id);
        end
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while (pending != 0 && n < 300) begin
            next_cycle();
            n++;
        end
        if (n >= 300) begin
            timed_out = 1'b1;
            $display("timeout: %0d flits never left the router in test %0d", pending, test_id);
        end
    endtask

    task automatic drive_flit(input int port, input logic [2:0] tgt, input logic qos,
                              input logic [7:0] data);
        in_valid[port] = 1'b1;
        in_flit[port]  = {2'b01, qos, 2'(port), 4'(seq), 3'b000, tgt, data};
        seq++;
    endtask

    task automatic run_table_test(input int t, input int mode);
        int         max_off;
        logic [2:0] mask;
        test_id = t;
        mode_r  = 3'(mode);
        hold    = (mode == M_BP);
        start_s = 1'b1;
        max_off = 0;
        for (int k = 0; k < N_STIM; k++) begin
            if (int'(stim[k].test) == t && int'(stim[k].off) > max_off) max_off = stim[k].off;
        end
        for (int c = 0; c <= max_off; c++) begin
            next_cycle();
            mask = '0;
            for (int k = 0; k < N_STIM; k++) begin
                if (int'(stim[k].test) == t && int'(stim[k].off) == c) mask[stim[k].port] = 1'b1;
            end
            wait_credit(mask);
            if (timed_out) return;
            for (int k = 0; k < N_STIM; k++) begin
                if (int'(stim[k].test) == t && int'(stim[k].off) == c)
                    drive_flit(stim[k].port, stim[k].tgt, stim[k].qos, stim[k].data);
            end
        end
        next_cycle();
        if (mode == M_BP) begin
            repeat (20) next_cycle();
            hold = 1'b0;    // release east credits
        end
        wait_drained();
        if (timed_out) return;
        end_s = 1'b1;
        next_cycle();
    endtask

    // no U-turn: west input only goes east or ejects, east input only west or ejects
    task automatic run_random_test(input int t);
        int         port;
        logic [2:0] tgt;
        test_id = t;
        mode_r  = 3'(M_ROUTE);
        start_s = 1'b1;
        for (int n = 0; n < 12; n++) begin
            next_cycle();
            rng  = xorshift32(rng);
            port = int'(rng[7:0]) % 3;
            if (port == P_W) tgt = 3'(3 + int'(rng[15:8]) % 5);
            else if (port == P_E) tgt = 3'(int'(rng[15:8]) % 4);
            else tgt = rng[10:8];
            wait_credit(3'b001 << port);
            if (timed_out) return;
            drive_flit(port, tgt, rng[16], rng[31:24]);
        end
        next_cycle();
        wait_drained();
        if (timed_out) return;
        end_s = 1'b1;
        next_cycle();
    endtask

    // ==================================================
    // main sequence
    // ==================================================
    initial begin
        rst_n_i    = 1'b0;
        in_valid   = '0;
        in_flit    = '0;
        out_credit = '0;
        mode_r     = '0;
        hold       = 1'b0;
        start_s    = 1'b0;
        end_s      = 1'b0;
        done_s     = 1'b0;
        timed_out  = 1'b0;
        test_id    = 0;
        seq        = 0;
        rng        = 32'h69ce;
        repeat (16) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        repeat (4) next_cycle();    // idle, checker watches for stray valids
        for (int t = 0; t <= M_BP; t++) begin
            if (!timed_out) run_table_test(t, t);
        end
        if (!timed_out) run_random_test(5);
        done_s = 1'b1;
        next_cycle();
        next_cycle();
        if (timed_out || err_cnt != 0) begin
            $display("Result: FAILED");
        end else begin
            $display("Result: PASSED");
        end
        $finish;
    end

endmodule

/* verif/node_checker.sv */
/*
 * scoreboard for the row router
 * predicts the output of every injected flit from the X rule,
 * matches outputs per link, checks order, latency, QoS and round robin
 */

`timescale 1ns/1ps
`include "node_macros.svh"

module node_checker #(
    parameter int LOCAL_X = 3
) (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic [2:0]                    in_valid_i,     // a, w, e
    input  logic [2:0][`NODE_FLIT_W-1:0]  in_flit_i,
    input  logic [2:0]                    in_credit_i,
    input  logic [2:0]                    out_valid_i,    // b, e, w
    input  logic [2:0][`NODE_FLIT_W-1:0]  out_flit_i,
    input  logic [2:0]                    mode_i,
    input  logic                          hold_i,
    input  logic                          start_i,
    input  logic                          end_i,
    input  logic                          done_i,
    input  int                            test_id_i,
    output int                            err_o,
    output int                            pending_o
);

    import node_flit_pkg::*;

    typedef struct packed {
        logic [`NODE_FLIT_W-1:0] flit;
        logic [1:0]              src;
        logic [31:0]             cyc;
    } exp_t;

    exp_t exp_q [3][$];
    int   cyc = 0;
    int   n_flits = 0;
    int   n_tests = 0;
    int   n_test_flits = 0;
    int   bp_cnt = 0;
    int   last_src = -1;
    logic first_e = 1'b1;
    logic hold_q = 1'b0;
    logic seen_inject = 1'b0;

    initial err_o = 0;
    initial pending_o = 0;

    // X rule: 0 eject, 1 east, 2 west
    function automatic int expected_out(input logic [`NODE_FLIT_W-1:0] flit);
        int tx;
        tx = int'(flit[TGT_LO +: `NODE_COORD_W]);
        if (tx > LOCAL_X) return 1;
        if (tx < LOCAL_X) return 2;
        return 0;
    endfunction

    task automatic report_error(input string msg);
        err_o++;
        $display("error %0t: %s", $time, msg);
    endtask

    task automatic check_output(input int o);
        int   idx;
        exp_t e;
        idx = -1;
        for (int k = 0; k < exp_q[o].size(); k++) begin
            if (idx < 0 && exp_q[o][k].flit == out_flit_i[o]) idx = k;
        end
        if (idx < 0) begin
            report_error($sformatf("unexpected flit %h on output %0d", out_flit_i[o], o));
            return;
        end
        e = exp_q[o][idx];
        for (int k = 0; k < idx; k++) begin
            if (exp_q[o][k].src == e.src) begin
                report_error($sformatf("flit %h overtook an older flit of input %0d",
                                       e.flit, e.src));
            end
        end
        if (mode_i == 3'd1) begin    // uncontended latency
            if (cyc - int'(e.cyc) != 2)
                report_error($sformatf("latency %0d, expected 2", cyc - int'(e.cyc)));
            if (!in_credit_i[e.src])
                report_error($sformatf("no credit pulse on input %0d with its flit", e.src));
        end
        if (mode_i == 3'd2 && o == 1 && first_e) begin
            if (!out_flit_i[o][QOS_POS]) report_error("qos 0 flit left before qos 1 flit");
            first_e = 1'b0;
        end
        if (mode_i == 3'd3 && o == 1) begin
            if (last_src == int'(e.src))
                report_error($sformatf("input %0d won twice in a row", e.src));
            last_src = int'(e.src);
        end
        exp_q[o].delete(idx);
        n_flits++;
        n_test_flits++;
    endtask

    // ==================================================
    // sampling at each rising edge
    // ==================================================
    always @(posedge clk) begin : watch
        exp_t e;
        if (!rst_n_i) begin
            if (out_valid_i != 3'b000 || in_credit_i != 3'b000)
                report_error("valid or credit high during reset");
            for (int o = 0; o < 3; o++) exp_q[o].delete();
        end else begin
            if (!seen_inject && (out_valid_i != 3'b000 || in_credit_i != 3'b000))
                report_error("valid or credit high before any traffic");
            if (start_i) begin
                first_e      = 1'b1;
                last_src     = -1;
                bp_cnt       = 0;
                n_test_flits = 0;
            end
            for (int o = 0; o < 3; o++) begin
                if (out_valid_i[o]) check_output(o);
            end
            if (hold_i && out_valid_i[1]) bp_cnt++;
            if (hold_q && !hold_i && bp_cnt != `NODE_CREDITS)
                report_error($sformatf("%0d flits left with credits held, expected %0d",
                                       bp_cnt, `NODE_CREDITS));
            for (int i = 0; i < 3; i++) begin
                if (in_valid_i[i]) begin
                    e.flit = in_flit_i[i];
                    e.src  = 2'(i);
                    e.cyc  = 32'(cyc);
                    exp_q[expected_out(in_flit_i[i])].push_back(e);
                    seen_inject = 1'b1;
                end
            end
            if (end_i) begin
                n_tests++;
                if (exp_q[0].size() + exp_q[1].size() + exp_q[2].size() != 0)
                    report_error("flits were lost in the router");
                $display("test %0d (mode %0d) done: %0d flits, %0d errors so far",
                         test_id_i, mode_i, n_test_flits, err_o);
            end
            if (done_i)
                $display("%0d tests, %0d flits checked, %0d errors", n_tests, n_flits, err_o);
        end
        hold_q    = hold_i;
        cyc       = cyc + 1;
        pending_o = exp_q[0].size() + exp_q[1].size() + exp_q[2].size();
    end

endmodule

/* verif/node_asserts.sv */
/*
 * concurrent checks on one output port
 * credit gating of valids, single grant per cycle,
 * credit counter range
 */

`timescale 1ns/1ps
`include "node_macros.svh"

module node_asserts #(
    parameter int N_REQ = 2,
    parameter int CNT_W = 3
) (
    input logic             clk,
    input logic             rst_n_i,
    input logic [N_REQ-1:0] gnt_i,
    input logic             valid_i,
    input logic [CNT_W-1:0] cnt_i
);

    a_valid_needs_credit: assert property (@(posedge clk) disable iff (!rst_n_i)
        valid_i |-> ($past(cnt_i) != '0))
        else $error("valid raised without a credit in the cycle before");

    a_one_grant: assert property (@(posedge clk) disable iff (!rst_n_i)
        $onehot0(gnt_i))
        else $error("more than one grant in a cycle");

    // counter never exceeds the downstream buffer depth
    a_cnt_range: assert property (@(posedge clk) disable iff (!rst_n_i)
        cnt_i <= CNT_W'(`NODE_CREDITS))
        else $error("credit counter above its initial value");

endmodule

bind node_out_port node_asserts #(.N_REQ(N_REQ), .CNT_W(CNT_W)) u_node_asserts (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .gnt_i   (gnt_o),
    .valid_i (valid_o),
    .cnt_i   (credit_cnt)
);

/* hw/node_row_router.sv */
/*
 * router node for one row of the mesh
 * three input FIFOs (a, w, e) feed three output ports (b, e, w),
 * X-only routing, credit flow control on every link
 */

`timescale 1ns/1ps
`include "node_macros.svh"

module node_row_router #(
    parameter int LOCAL_X = 0
) (
    input  logic                    clk,
    input  logic                    rst_n_i,

    // local inject
    input  logic                    a_valid_i,
    input  logic [`NODE_FLIT_W-1:0] a_flit_i,
    output logic                    a_credit_o,

    // from west neighbour
    input  logic                    w_valid_i,
    input  logic [`NODE_FLIT_W-1:0] w_flit_i,
    output logic                    w_credit_o,

    // from east neighbour
    input  logic                    e_valid_i,
    input  logic [`NODE_FLIT_W-1:0] e_flit_i,
    output logic                    e_credit_o,

    // local eject
    output logic                    b_valid_o,
    output logic [`NODE_FLIT_W-1:0] b_flit_o,
    input  logic                    b_credit_i,

    // to east neighbour
    output logic                    e_valid_o,
    output logic [`NODE_FLIT_W-1:0] e_flit_o,
    input  logic                    e_credit_i,

    // to west neighbour
    output logic                    w_valid_o,
    output logic [`NODE_FLIT_W-1:0] w_flit_o,
    input  logic                    w_credit_i
);

    import node_route_pkg::*;

    // per input, indexed by DIR_*
    logic [`NODE_NUM_OUT-1:0] req_a, req_w, req_e;
    logic [`NODE_NUM_OUT-1:0] gnt_a, gnt_w, gnt_e;
    logic [`NODE_FLIT_W-1:0]  head_a, head_w, head_e;

    // per output, indexed by contender slot
    logic [2:0] ob_gnt;    // a, w, e
    logic [1:0] oe_gnt;    // a, w
    logic [1:0] ow_gnt;    // a, e

    // ==================================================
    // input buffers
    // ==================================================
    node_in_buffer #(.LOCAL_X(LOCAL_X)) u_in_a (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .valid_i     (a_valid_i),
        .flit_i      (a_flit_i),
        .credit_o    (a_credit_o),
        .gnt_i       (gnt_a),
        .head_req_o  (req_a),
        .head_flit_o (head_a)
    );

    node_in_buffer #(.LOCAL_X(LOCAL_X)) u_in_w (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .valid_i     (w_valid_i),
        .flit_i      (w_flit_i),
        .credit_o    (w_credit_o),
        .gnt_i       (gnt_w),
        .head_req_o  (req_w),
        .head_flit_o (head_w)
    );

    node_in_buffer #(.LOCAL_X(LOCAL_X)) u_in_e (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .valid_i     (e_valid_i),
        .flit_i      (e_flit_i),
        .credit_o    (e_credit_o),
        .gnt_i       (gnt_e),
        .head_req_o  (req_e),
        .head_flit_o (head_e)
    );

    // ==================================================
    // output ports
    // ==================================================
    node_out_port #(.N_REQ(3)) u_out_b (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .req_i    ({req_e[DIR_B], req_w[DIR_B], req_a[DIR_B]}),
        .flit_i   ({head_e, head_w, head_a}),
        .gnt_o    (ob_gnt),
        .credit_i (b_credit_i),
        .valid_o  (b_valid_o),
        .flit_o   (b_flit_o)
    );

    // a flit from the east never turns back east
    node_out_port #(.N_REQ(2)) u_out_e (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .req_i    ({req_w[DIR_E], req_a[DIR_E]}),
        .flit_i   ({head_w, head_a}),
        .gnt_o    (oe_gnt),
        .credit_i (e_credit_i),
        .valid_o  (e_valid_o),
        .flit_o   (e_flit_o)
    );

    node_out_port #(.N_REQ(2)) u_out_w (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .req_i    ({req_e[DIR_W], req_a[DIR_W]}),
        .flit_i   ({head_e, head_a}),
        .gnt_o    (ow_gnt),
        .credit_i (w_credit_i),
        .valid_o  (w_valid_o),
        .flit_o   (w_flit_o)
    );

    // ==================================================
    // grants back to the buffers
    // ==================================================
    assign gnt_a[DIR_B] = ob_gnt[0];
    assign gnt_a[DIR_E] = oe_gnt[0];
    assign gnt_a[DIR_W] = ow_gnt[0];

    assign gnt_w[DIR_B] = ob_gnt[1];
    assign gnt_w[DIR_E] = oe_gnt[1];
    assign gnt_w[DIR_W] = 1'b0;    // no U-turn

    assign gnt_e[DIR_B] = ob_gnt[2];
    assign gnt_e[DIR_E] = 1'b0;    // no U-turn
    assign gnt_e[DIR_W] = ow_gnt[1];

endmodule

/* hw/node_out_port.sv */
/*
 * one output link of the row router
 * QoS first, round robin among equals, gated by the
 * downstream credit count, winner registered onto the link
 */

`timescale 1ns/1ps
`include "node_macros.svh"

module node_out_port #(
    parameter int N_REQ = 2    // contenders, 2 or 3
) (
    input  logic                               clk,
    input  logic                               rst_n_i,

    input  logic [N_REQ-1:0]                   req_i,
    input  logic [N_REQ-1:0][`NODE_FLIT_W-1:0] flit_i,
    output logic [N_REQ-1:0]                   gnt_o,

    input  logic                               credit_i,
    output logic                               valid_o,
    output logic [`NODE_FLIT_W-1:0]            flit_o
);

    import node_flit_pkg::*;

    localparam int PTR_W = $clog2(N_REQ);
    localparam int CNT_W = $clog2(`NODE_CREDITS + 1);
    localparam logic [CNT_W-1:0] CNT_INIT = CNT_W'(`NODE_CREDITS);

    logic [N_REQ-1:0]        qos_vec;
    logic [N_REQ-1:0]        hi_req;
    logic [N_REQ-1:0]        cand;
    logic [N_REQ-1:0]        pick;
    logic [PTR_W-1:0]        rr_ptr;     // highest priority slot
    logic [PTR_W-1:0]        win_idx;
    logic [CNT_W-1:0]        credit_cnt;
    logic                    can_send;
    logic                    send;
    logic [`NODE_FLIT_W-1:0] win_flit;

    // ==================================================
    // arbitration
    // ==================================================
    always_comb begin
        for (int i = 0; i < N_REQ; i++) begin
            qos_vec[i] = flit_qos(flit_i[i]);
        end
    end

    assign hi_req = req_i & qos_vec;
    assign cand   = (|hi_req) ? hi_req : req_i;    // qos 1 class shadows the rest

    // first candidate at or after rr_ptr
    always_comb begin : rr_pick
        int   idx;
        logic found;
        pick    = '0;
        win_idx = '0;
        found   = 1'b0;
        for (int i = 0; i < N_REQ; i++) begin
            idx = (int'(rr_ptr) + i) % N_REQ;
            if (!found && cand[idx]) begin
                found     = 1'b1;
                pick[idx] = 1'b1;
                win_idx   = PTR_W'(idx);
            end
        end
    end

    assign can_send = (credit_cnt != '0);
    assign gnt_o    = can_send ? pick : '0;    // no credit, nobody moves
    assign send     = |gnt_o;
    assign win_flit = flit_i[win_idx];

    // ==================================================
    // credits and pointer
    // ==================================================
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            credit_cnt <= CNT_INIT;
        end else begin
            case ({send, credit_i})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;    // idle, or send and return together
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rr_ptr <= '0;
        end else if (send) begin
            // step past the winner
            rr_ptr <= (win_idx == PTR_W'(N_REQ - 1)) ? '0 : win_idx + 1'b1;
        end
    end

    // ==================================================
    // output register
    // ==================================================
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= send;
        end
    end

    always_ff @(posedge clk) begin
        if (send) begin
            flit_o <= win_flit;
        end
    end

endmodule

/* hw/node_in_buffer.sv */
/*
 * input FIFO of one router link
 * keeps the routed direction next to each flit,
 * presents the head request and returns one credit per pop
 */

`timescale 1ns/1ps
`include "node_macros.svh"

module node_in_buffer #(
    parameter int LOCAL_X = 0
) (
    input  logic                     clk,
    input  logic                     rst_n_i,

    input  logic                     valid_i,
    input  logic [`NODE_FLIT_W-1:0]  flit_i,
    output logic                     credit_o,    // one pulse per flit leaving

    input  logic [`NODE_NUM_OUT-1:0] gnt_i,
    output logic [`NODE_NUM_OUT-1:0] head_req_o,
    output logic [`NODE_FLIT_W-1:0]  head_flit_o
);

    import node_flit_pkg::*;
    import node_route_pkg::*;

    localparam int PTR_W = $clog2(`NODE_BUF_DEPTH);
    localparam logic [`NODE_COORD_W-1:0] MY_X = LOCAL_X[`NODE_COORD_W-1:0];

    // ==================================================
    // storage and pointers
    // ==================================================
    logic [`NODE_FLIT_W-1:0]  flit_mem  [`NODE_BUF_DEPTH];
    logic [`NODE_NUM_OUT-1:0] route_mem [`NODE_BUF_DEPTH];

    logic [PTR_W:0] wr_ptr;    // msb is the wrap bit
    logic [PTR_W:0] rd_ptr;

    logic empty;
    logic full;
    logic push;
    logic pop;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                   (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

    // upstream only sends with a credit, so full should never block here
    assign push = valid_i && !full;
    assign pop  = (|gnt_i) && !empty;

    // route is resolved once, on the way in
    always_ff @(posedge clk) begin
        if (push) begin
            flit_mem[wr_ptr[PTR_W-1:0]]  <= flit_i;
            route_mem[wr_ptr[PTR_W-1:0]] <= route_dir(flit_tgt_x(flit_i), MY_X);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            credit_o <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            credit_o <= pop;    // slot freed, hand it back upstream
        end
    end

    // ==================================================
    // head of queue
    // ==================================================
    assign head_req_o  = empty ? '0 : route_mem[rd_ptr[PTR_W-1:0]];
    assign head_flit_o = flit_mem[rd_ptr[PTR_W-1:0]];

endmodule

/* hw/node_route_pkg.sv */
/*
 * output direction indices and the X routing rule
 */

`include "node_macros.svh"

package node_route_pkg;

    localparam int DIR_B = 0;   // local eject
    localparam int DIR_E = 1;   // to east neighbour
    localparam int DIR_W = 2;   // to west neighbour

    // one-hot output request for a target X seen from local_x
    function automatic logic [`NODE_NUM_OUT-1:0] route_dir(
        input logic [`NODE_COORD_W-1:0] tgt_x,
        input logic [`NODE_COORD_W-1:0] local_x
    );
        logic [`NODE_NUM_OUT-1:0] req;
        req = '0;
        if (tgt_x > local_x) begin
            req[DIR_E] = 1'b1;
        end else if (tgt_x < local_x) begin
            req[DIR_W] = 1'b1;
        end else begin
            req[DIR_B] = 1'b1;    // arrived
        end
        return req;
    endfunction

endpackage

/* hw/node_flit_pkg.sv */
/*
 * flit layout of the row router
 * field positions and helpers that pull qos and target X
 */

`include "node_macros.svh"

package node_flit_pkg;

    // ==================================================
    // field positions
    // ==================================================
    localparam int QOS_POS = 20;
    localparam int TGT_HI  = 13;
    localparam int TGT_LO  = 8;    // target X sits in the low bits of tgt

    // ==================================================
    // field extraction
    // ==================================================
    function automatic logic flit_qos(input logic [`NODE_FLIT_W-1:0] flit);
        return flit[QOS_POS];
    endfunction

    function automatic logic [`NODE_COORD_W-1:0] flit_tgt_x(
        input logic [`NODE_FLIT_W-1:0] flit
    );
        logic [TGT_HI-TGT_LO:0] tgt;
        tgt = flit[TGT_HI:TGT_LO];
        return tgt[`NODE_COORD_W-1:0];    // Y half of tgt is ignored
    endfunction

endpackage

/* include/node_macros.svh */
/*
 * shared sizing macros for the row router node
 * flit width, X coordinate width, input FIFO depth,
 * per-link credits and number of output links
 */

`ifndef NODE_MACROS_SVH
`define NODE_MACROS_SVH

// {type[1:0], qos, src[5:0], tgt[5:0], data[7:0]}
`define NODE_FLIT_W     23

// one row of an 8 wide mesh
`define NODE_COORD_W    3

`define NODE_BUF_DEPTH  4   // power of two, pointers wrap naturally

// sender credits start at the downstream FIFO depth
`define NODE_CREDITS    `NODE_BUF_DEPTH

`define NODE_NUM_OUT    3   // eject, east, west

`endif
